/* common/router_pkg.sv */
// shared types and widths for the mesh router node
package router_pkg;

	// node number in the 2x2 mesh
	localparam int DEST_W = 2;

	localparam int PAYLOAD_W = 14;

	// link word carries dest in the top bits, then payload
	localparam int LINK_DATA_W = DEST_W + PAYLOAD_W;

	// local, rx/tx side a, rx/tx side b
	localparam int NUM_PORTS = 3;

	// flit inside the router, frame flags active high
	typedef struct packed {
		logic                 sof;
		logic                 eof;
		logic [DEST_W-1:0]    dest;
		logic                 rem;
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

	// LocalLink word as seen on the wire
	typedef struct packed {
		logic                   sof_n;
		logic                   eof_n;
		logic                   rem;
		logic [LINK_DATA_W-1:0] data;
	} ll_t;

	// output ports; inputs use the same numbering
	typedef enum logic [1:0] {
		PORT_LOCAL = 2'd0,
		PORT_TX_A  = 2'd1,
		PORT_TX_B  = 2'd2
	} port_e;

endpackage

/* link/link_rx.sv */
`timescale 1ns/1ps

// LocalLink receive register, cannot stall the sender
module link_rx (
	input  logic              clk,
	input  logic              rst_n,
	input  router_pkg::ll_t   rx,
	input  logic              src_rdy_n,
	output logic              flit_valid,
	output router_pkg::flit_t flit
);

	logic in_frame;
	logic accept;

	// stray words between frames are dropped unless they open one
	assign accept = !src_rdy_n && (in_frame || !rx.sof_n);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_frame   <= 1'b0;
			flit_valid <= 1'b0;
		end else begin
			flit_valid <= accept;
			if (accept)
				in_frame <= rx.eof_n;
		end
	end

	// data word splits into dest on top, payload below
	always_ff @(posedge clk) begin
		if (accept) begin
			flit.sof     <= !rx.sof_n;
			flit.eof     <= !rx.eof_n;
			flit.dest    <= rx.data[router_pkg::LINK_DATA_W-1 -: router_pkg::DEST_W];
			flit.rem     <= rx.rem;
			flit.payload <= rx.data[router_pkg::PAYLOAD_W-1:0];
		end
	end

endmodule

/* link/link_tx.sv */
`timescale 1ns/1ps

// one-word LocalLink transmit slice
module link_tx (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  router_pkg::flit_t in_flit,
	output logic              in_ready,
	output router_pkg::ll_t   tx,
	output logic              src_rdy_n,
	input  logic              dst_rdy_n
);

	logic full_q;
	logic leaving;
	router_pkg::flit_t data_q;

	assign leaving  = full_q && !dst_rdy_n;
	// refill in the same cycle the held word goes out
	assign in_ready = !full_q || leaving;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			full_q <= 1'b0;
		else if (in_valid && in_ready)
			full_q <= 1'b1;
		else if (leaving)
			full_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			data_q <= in_flit;
	end

	// back to active-low framing on the wire
	assign src_rdy_n = !full_q;
	assign tx.sof_n  = !data_q.sof;
	assign tx.eof_n  = !data_q.eof;
	assign tx.rem    = data_q.rem;
	assign tx.data   = {data_q.dest, data_q.payload};

endmodule

/* router/input_unit.sv */
`timescale 1ns/1ps

// per-input flit buffer with route lookup on the head start flit
module input_unit #(
	parameter int NODE_ID   = 3,
	parameter int BUF_DEPTH = 8
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                wr_valid,
	input  router_pkg::flit_t                   wr_flit,
	output logic                                not_full,
	output logic                                room,
	output logic                                head_valid,
	output router_pkg::flit_t                   head_flit,
	output logic [router_pkg::NUM_PORTS-1:0]    req,
	input  logic                                pop
);

	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);
	localparam logic [router_pkg::DEST_W-1:0] MY_ID = NODE_ID[router_pkg::DEST_W-1:0];

	router_pkg::flit_t mem [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	router_pkg::port_e route_q;
	router_pkg::port_e cur_route;

	// fixed mesh rule, low dest bit picks the link side
	function automatic router_pkg::port_e route_of(input logic [router_pkg::DEST_W-1:0] dest);
		if (dest == MY_ID)
			return router_pkg::PORT_LOCAL;
		if (dest[0] != MY_ID[0])
			return router_pkg::PORT_TX_A;
		return router_pkg::PORT_TX_B;
	endfunction

	assign not_full   = count < CNT_W'(BUF_DEPTH);
	assign room       = count < CNT_W'(BUF_DEPTH - 2);
	assign head_valid = count != '0;
	assign head_flit  = mem[rd_ptr];
	assign push       = wr_valid && not_full;

	// body flits follow the route latched from their start flit
	assign cur_route = head_flit.sof ? route_of(head_flit.dest) : route_q;

	always_comb begin
		for (int i = 0; i < router_pkg::NUM_PORTS; i++)
			req[i] = head_valid && (int'(cur_route) == i);
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_flit;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			route_q <= router_pkg::PORT_LOCAL;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			if (pop && head_flit.sof)
				route_q <= cur_route;
		end
	end

endmodule

/* router/output_port.sv */
`timescale 1ns/1ps

// wormhole allocator for one output, round robin between packets
module output_port (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic [router_pkg::NUM_PORTS-1:0]              head_valid,
	input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] head_flit,
	input  logic [router_pkg::NUM_PORTS-1:0]              req,
	output logic [router_pkg::NUM_PORTS-1:0]              pop,
	output logic                                          out_valid,
	output router_pkg::flit_t                             out_flit,
	input  logic                                          out_ready
);

	localparam int N     = router_pkg::NUM_PORTS;
	localparam int IDX_W = $clog2(N);

	typedef enum logic {
		ST_IDLE,
		ST_LOCKED
	} state_e;

	state_e state_q;
	logic [IDX_W-1:0] owner_q;
	logic [IDX_W-1:0] prio_q;
	logic [IDX_W-1:0] grant_idx;
	logic [IDX_W-1:0] next_prio;
	logic [IDX_W-1:0] sel;
	logic found;
	logic sel_valid;

	// first start flit asking for us, searching from prio_q
	always_comb begin
		int idx;
		found     = 1'b0;
		grant_idx = '0;
		for (int k = 0; k < N; k++) begin
			idx = (int'(prio_q) + k) % N;
			if (!found && req[idx] && head_valid[idx] && head_flit[idx].sof) begin
				found     = 1'b1;
				grant_idx = IDX_W'(idx);
			end
		end
	end

	assign next_prio = (grant_idx == IDX_W'(N - 1)) ? '0 : grant_idx + 1'b1;

	assign sel = (state_q == ST_LOCKED) ? owner_q : grant_idx;
	assign sel_valid = (state_q == ST_LOCKED) ? (head_valid[owner_q] && req[owner_q]) : found;

	assign out_valid = sel_valid;
	assign out_flit  = head_flit[sel];

	always_comb begin
		pop = '0;
		if (sel_valid && out_ready)
			pop[sel] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			owner_q <= '0;
			prio_q  <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (found) begin
						owner_q <= grant_idx;
						prio_q  <= next_prio;
						// lock even when stalled so the shown flit stays put
						if (!(out_ready && out_flit.eof))
							state_q <= ST_LOCKED;
					end
				end
				ST_LOCKED: begin
					if (sel_valid && out_ready && out_flit.eof)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hdl/router_node.sv */
`timescale 1ns/1ps

// one node of the 2x2 mesh: inject/eject port plus two LocalLink sides
module router_node #(
	parameter int NODE_ID   = 3,
	parameter int BUF_DEPTH = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              inj_valid,
	input  router_pkg::flit_t inj_flit,
	output logic              inj_ready,
	output logic              ej_valid,
	output router_pkg::flit_t ej_flit,
	input  logic              ej_ready,
	input  router_pkg::ll_t   rx_a,
	input  router_pkg::ll_t   rx_b,
	input  logic              rx_a_src_rdy_n,
	input  logic              rx_b_src_rdy_n,
	output logic              rx_a_nonfull,
	output logic              rx_b_nonfull,
	output router_pkg::ll_t   tx_a,
	output router_pkg::ll_t   tx_b,
	output logic              tx_a_src_rdy_n,
	output logic              tx_b_src_rdy_n,
	input  logic              tx_a_dst_rdy_n,
	input  logic              tx_b_dst_rdy_n
);

	localparam int N = router_pkg::NUM_PORTS;

	logic [N-1:0] wr_valid;
	logic [N-1:0] not_full;
	logic [N-1:0] room;
	logic [N-1:0] head_valid;
	logic [N-1:0] out_valid;
	logic [N-1:0] out_ready;
	router_pkg::flit_t [N-1:0] wr_flit;
	router_pkg::flit_t [N-1:0] head_flit;
	router_pkg::flit_t [N-1:0] out_flit;

	// indexed [input][output]
	logic [N-1:0] req_from_in [N];
	logic [N-1:0] pop_to_in [N];
	// indexed [output][input]
	logic [N-1:0] req_to_out [N];
	logic [N-1:0] pop_from_out [N];

	// local inject and eject
	assign wr_valid[router_pkg::PORT_LOCAL] = inj_valid;
	assign wr_flit[router_pkg::PORT_LOCAL]  = inj_flit;
	assign inj_ready = not_full[router_pkg::PORT_LOCAL];
	assign ej_valid  = out_valid[router_pkg::PORT_LOCAL];
	assign ej_flit   = out_flit[router_pkg::PORT_LOCAL];
	assign out_ready[router_pkg::PORT_LOCAL] = ej_ready;

	// link senders need the two-word margin
	assign rx_a_nonfull = room[router_pkg::PORT_TX_A];
	assign rx_b_nonfull = room[router_pkg::PORT_TX_B];

	link_rx u_rx_a (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx         (rx_a),
		.src_rdy_n  (rx_a_src_rdy_n),
		.flit_valid (wr_valid[router_pkg::PORT_TX_A]),
		.flit       (wr_flit[router_pkg::PORT_TX_A])
	);

	link_rx u_rx_b (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx         (rx_b),
		.src_rdy_n  (rx_b_src_rdy_n),
		.flit_valid (wr_valid[router_pkg::PORT_TX_B]),
		.flit       (wr_flit[router_pkg::PORT_TX_B])
	);

	for (genvar i = 0; i < N; i++) begin : g_in
		input_unit #(
			.NODE_ID   (NODE_ID),
			.BUF_DEPTH (BUF_DEPTH)
		) u_in (
			.clk        (clk),
			.rst_n      (rst_n),
			.wr_valid   (wr_valid[i]),
			.wr_flit    (wr_flit[i]),
			.not_full   (not_full[i]),
			.room       (room[i]),
			.head_valid (head_valid[i]),
			.head_flit  (head_flit[i]),
			.req        (req_from_in[i]),
			.pop        (|pop_to_in[i])
		);

		// swap request and pop grids between input and output view
		for (genvar o = 0; o < N; o++) begin : g_xbar
			assign req_to_out[o][i] = req_from_in[i][o];
			assign pop_to_in[i][o]  = pop_from_out[o][i];
		end
	end

	for (genvar o = 0; o < N; o++) begin : g_out
		output_port u_out (
			.clk        (clk),
			.rst_n      (rst_n),
			.head_valid (head_valid),
			.head_flit  (head_flit),
			.req        (req_to_out[o]),
			.pop        (pop_from_out[o]),
			.out_valid  (out_valid[o]),
			.out_flit   (out_flit[o]),
			.out_ready  (out_ready[o])
		);
	end

	link_tx u_tx_a (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (out_valid[router_pkg::PORT_TX_A]),
		.in_flit   (out_flit[router_pkg::PORT_TX_A]),
		.in_ready  (out_ready[router_pkg::PORT_TX_A]),
		.tx        (tx_a),
		.src_rdy_n (tx_a_src_rdy_n),
		.dst_rdy_n (tx_a_dst_rdy_n)
	);

	link_tx u_tx_b (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (out_valid[router_pkg::PORT_TX_B]),
		.in_flit   (out_flit[router_pkg::PORT_TX_B]),
		.in_ready  (out_ready[router_pkg::PORT_TX_B]),
		.tx        (tx_b),
		.src_rdy_n (tx_b_src_rdy_n),
		.dst_rdy_n (tx_b_dst_rdy_n)
	);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

// free-running testbench clock
module tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

/* bench/tb_router_node.sv */
`timescale 1ns/1ps

module tb_router_node;

	localparam int NODE_ID    = 3;
	localparam int BUF_DEPTH  = 8;
	localparam int PKTS       = 150;
	localparam int MAX_CYCLES = PKTS * 3 * 4 * 10 + 1000;
	localparam int TOP        = router_pkg::PAYLOAD_W - 1;

	logic clk;
	logic rst_n;
	logic inj_valid;
	logic inj_ready;
	logic ej_valid;
	logic ej_ready;
	logic local_ok;
	logic [1:0] rx_src_rdy_n;
	logic [1:0] rx_nonfull;
	logic [1:0] rx_open;
	logic tx_a_src_rdy_n;
	logic tx_b_src_rdy_n;
	logic tx_a_dst_rdy_n;
	logic tx_b_dst_rdy_n;
	router_pkg::flit_t inj_flit;
	router_pkg::flit_t ej_flit;
	router_pkg::ll_t rx_word [2];
	router_pkg::ll_t tx_a;
	router_pkg::ll_t tx_b;

	integer seed = 32'hbd0d_2225;
	int mismatches = 0;
	int other_errors = 0;
	int delivered = 0;
	int cycles = 0;
	logic done;

	// model queues indexed by source * 3 + output
	router_pkg::flit_t exp_q [9][$];
	router_pkg::flit_t cur [3];
	logic has_cur [3];
	int pkts_left [3];
	int flit_idx [3];
	int pkt_len [3];
	logic [router_pkg::DEST_W-1:0] pkt_dest [3];
	int lock_src [3];
	logic ej_stalled;
	router_pkg::flit_t ej_shown;

	tb_clock #(.PERIOD_NS(20)) u_clk (.clk(clk));

	router_node #(
		.NODE_ID   (NODE_ID),
		.BUF_DEPTH (BUF_DEPTH)
	) dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.inj_valid      (inj_valid),
		.inj_flit       (inj_flit),
		.inj_ready      (inj_ready),
		.ej_valid       (ej_valid),
		.ej_flit        (ej_flit),
		.ej_ready       (ej_ready),
		.rx_a           (rx_word[0]),
		.rx_b           (rx_word[1]),
		.rx_a_src_rdy_n (rx_src_rdy_n[0]),
		.rx_b_src_rdy_n (rx_src_rdy_n[1]),
		.rx_a_nonfull   (rx_nonfull[0]),
		.rx_b_nonfull   (rx_nonfull[1]),
		.tx_a           (tx_a),
		.tx_b           (tx_b),
		.tx_a_src_rdy_n (tx_a_src_rdy_n),
		.tx_b_src_rdy_n (tx_b_src_rdy_n),
		.tx_a_dst_rdy_n (tx_a_dst_rdy_n),
		.tx_b_dst_rdy_n (tx_b_dst_rdy_n)
	);

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// own node ejects and the low dest bit picks the link side
	function automatic int route_for(input logic [router_pkg::DEST_W-1:0] dest);
		logic [router_pkg::DEST_W-1:0] me;
		me = router_pkg::DEST_W'(NODE_ID);
		if (dest == me)
			return int'(router_pkg::PORT_LOCAL);
		if (dest[0] != me[0])
			return int'(router_pkg::PORT_TX_A);
		return int'(router_pkg::PORT_TX_B);
	endfunction

	function automatic router_pkg::ll_t to_link_word(input router_pkg::flit_t f);
		router_pkg::ll_t w;
		w.sof_n = !f.sof;
		w.eof_n = !f.eof;
		w.rem   = f.rem;
		w.data  = {f.dest, f.payload};
		return w;
	endfunction

	function automatic router_pkg::flit_t to_flit(input router_pkg::ll_t w);
		router_pkg::flit_t f;
		f.sof     = !w.sof_n;
		f.eof     = !w.eof_n;
		f.dest    = w.data[router_pkg::LINK_DATA_W-1 -: router_pkg::DEST_W];
		f.rem     = w.rem;
		f.payload = w.data[TOP:0];
		return f;
	endfunction

	function automatic logic more_to_send(input int s);
		return flit_idx[s] != 0 || pkts_left[s] > 0;
	endfunction

	task automatic check_flit(input router_pkg::flit_t got, input router_pkg::flit_t exp,
			input string what);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_link(input router_pkg::ll_t got, input router_pkg::ll_t exp,
			input string what);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// source id sits in the top payload bits and 3 marks a stray word
	task automatic next_flit(input int s);
		if (flit_idx[s] == 0) begin
			pkt_len[s]  = 1 + rand_below(4);
			pkt_dest[s] = router_pkg::DEST_W'(rand_below(4));
			pkts_left[s]--;
		end
		cur[s].sof     = flit_idx[s] == 0;
		cur[s].eof     = flit_idx[s] == pkt_len[s] - 1;
		cur[s].dest    = pkt_dest[s];
		cur[s].rem     = 1'(rand_below(2));
		cur[s].payload = {2'(s), 12'(rand_below(4096))};
		flit_idx[s]++;
		if (flit_idx[s] == pkt_len[s])
			flit_idx[s] = 0;
		has_cur[s] = 1'b1;
	endtask

	task automatic drive_local();
		logic sent;
		// ready seen at the last falling edge means the flit went in
		sent = inj_valid && local_ok;
		if (sent)
			has_cur[0] = 1'b0;
		if (!has_cur[0] && more_to_send(0))
			next_flit(0);
		// a waiting flit keeps valid up, a fresh one may idle first
		inj_valid = has_cur[0] && ((inj_valid && !sent) || rand_below(4) != 0);
		inj_flit  = cur[0];
		local_ok  = inj_ready;
		if (inj_valid && local_ok)
			exp_q[route_for(cur[0].dest)].push_back(cur[0]);
	endtask

	task automatic drive_rx(input int s);
		int r;
		r = s - 1;
		if (!has_cur[s] && more_to_send(s))
			next_flit(s);
		if (has_cur[s] && rx_nonfull[r] && rand_below(3) != 0) begin
			rx_word[r]      = to_link_word(cur[s]);
			rx_src_rdy_n[r] = 1'b0;
			rx_open[r]      = !cur[s].eof;
			exp_q[s * 3 + route_for(cur[s].dest)].push_back(cur[s]);
			has_cur[s] = 1'b0;
		end else if (!rx_open[r] && rand_below(16) == 0) begin
			rx_word[r].sof_n = 1'b1;
			rx_word[r].eof_n = 1'(rand_below(2));
			rx_word[r].rem   = 1'(rand_below(2));
			rx_word[r].data  = {2'(rand_below(4)), 2'b11, 12'(rand_below(4096))};
			rx_src_rdy_n[r]  = 1'b0;
		end else begin
			rx_src_rdy_n[r] = 1'b1;
		end
	endtask

	task automatic take_output(input int o, input router_pkg::flit_t got_f,
			input router_pkg::ll_t got_l);
		int src;
		router_pkg::flit_t exp;
		src = int'(got_f.payload[TOP -: 2]);
		if (src == 3) begin
			other_errors++;
			$display("stray rx word came out of output %0d at %0t", o, $time);
			return;
		end
		if (lock_src[o] < 0 && !got_f.sof) begin
			other_errors++;
			$display("output %0d sent a body flit outside a packet at %0t", o, $time);
		end else if (lock_src[o] >= 0 && (got_f.sof || src != lock_src[o])) begin
			other_errors++;
			$display("output %0d broke up a packet from source %0d at %0t", o, lock_src[o],
				$time);
		end
		lock_src[o] = got_f.eof ? -1 : src;
		if (exp_q[src * 3 + o].size() == 0) begin
			other_errors++;
			$display("output %0d sent an unexpected flit from source %0d at %0t", o, src, $time);
			return;
		end
		exp = exp_q[src * 3 + o].pop_front();
		if (o == 0)
			check_flit(got_f, exp, "eject flit");
		else
			check_link(got_l, to_link_word(exp), $sformatf("tx word on output %0d", o));
		delivered++;
	endtask

	task automatic watch_outputs();
		// a stalled eject port keeps showing the same flit
		if (ej_stalled) begin
			check_bit(ej_valid, 1'b1, "ej_valid while stalled");
			check_flit(ej_flit, ej_shown, "eject flit while stalled");
		end
		ej_ready       = rand_below(4) != 0;
		tx_a_dst_rdy_n = rand_below(4) == 0;
		tx_b_dst_rdy_n = rand_below(4) == 0;
		ej_stalled     = ej_valid && !ej_ready;
		ej_shown       = ej_flit;
		if (ej_valid && ej_ready)
			take_output(0, ej_flit, to_link_word(ej_flit));
		if (!tx_a_src_rdy_n && !tx_a_dst_rdy_n)
			take_output(1, to_flit(tx_a), tx_a);
		if (!tx_b_src_rdy_n && !tx_b_dst_rdy_n)
			take_output(2, to_flit(tx_b), tx_b);
	endtask

	initial begin
		int left;
		rst_n          = 1'b0;
		inj_valid      = 1'b0;
		inj_flit       = '0;
		local_ok       = 1'b0;
		ej_ready       = 1'b0;
		rx_word[0]     = '1;
		rx_word[1]     = '1;
		rx_src_rdy_n   = 2'b11;
		rx_open        = 2'b00;
		tx_a_dst_rdy_n = 1'b1;
		tx_b_dst_rdy_n = 1'b1;
		done           = 1'b0;
		ej_stalled     = 1'b0;
		ej_shown       = '0;
		for (int s = 0; s < 3; s++) begin
			pkts_left[s] = PKTS;
			flit_idx[s]  = 0;
			has_cur[s]   = 1'b0;
			cur[s]       = '0;
			lock_src[s]  = -1;
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_bit(ej_valid, 1'b0, "ej_valid after reset");
		check_bit(tx_a_src_rdy_n, 1'b1, "tx_a_src_rdy_n after reset");
		check_bit(tx_b_src_rdy_n, 1'b1, "tx_b_src_rdy_n after reset");

		while (!done && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
			drive_local();
			drive_rx(1);
			drive_rx(2);
			watch_outputs();
			left = 0;
			for (int q = 0; q < 9; q++)
				left += exp_q[q].size();
			done = left == 0;
			for (int s = 0; s < 3; s++)
				if (more_to_send(s) || has_cur[s])
					done = 1'b0;
		end

		if (!done) begin
			other_errors++;
			$display("timeout: traffic still pending after %0d cycles", cycles);
		end else begin
			// nothing may follow once every expected flit is out
			inj_valid      = 1'b0;
			rx_src_rdy_n   = 2'b11;
			ej_ready       = 1'b1;
			tx_a_dst_rdy_n = 1'b0;
			tx_b_dst_rdy_n = 1'b0;
			repeat (20) begin
				@(negedge clk);
				check_bit(ej_valid, 1'b0, "ej_valid after drain");
				check_bit(tx_a_src_rdy_n, 1'b1, "tx_a_src_rdy_n after drain");
				check_bit(tx_b_src_rdy_n, 1'b1, "tx_b_src_rdy_n after drain");
			end
		end

		$display("errors: %0d mismatches, %0d other, %0d flits delivered in %0d cycles",
			mismatches, other_errors, delivered, cycles);
		if (mismatches == 0 && other_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* sources.f */
common/router_pkg.sv
link/link_rx.sv
link/link_tx.sv
router/input_unit.sv
router/output_port.sv
hdl/router_node.sv
bench/tb_clock.sv
bench/tb_router_node.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_router_node
RTL_TOP   ?= router_node
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
RTL_SRCS  ?= common/router_pkg.sv link/link_rx.sv link/link_tx.sv \
             router/input_unit.sv router/output_port.sv hdl/router_node.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation ended without result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
